/* sources.f */
logic/csr_pkg.sv
logic/csr_file.sv
logic/csr_counters.sv
logic/csr_exec.sv
logic/csr_block.sv
test/csr_block_tb.sv

/* test/csr_tests.txt */
# name wid op(1 rw, 2 rs, 3 rc) addr use_imm imm rs1 rd stall expected_old bp, all hex
# expected_old is ignored for cycle and instret; for wtid and ltid it is the warp id
rw_s0_w0    0 1 340 0 00 12345678 01 0 00000000 0
rd_s0_w0    0 2 340 0 00 00000000 02 0 12345678 0
rs_s0_w0    0 2 340 1 05 00000000 03 0 12345678 0
rd_s0_rs    0 2 340 0 00 00000000 04 0 1234567d 0
rc_s0_w0    0 3 340 0 00 0000000f 05 0 1234567d 0
rd_s0_rc    0 3 340 1 00 00000000 06 0 12345670 0
rw_s1_w0    0 1 341 1 1f 00000000 07 0 00000000 0
rs_s1_w0    0 2 341 0 00 a5000000 08 0 0000001f 0
rc_s1_w0    0 3 341 1 0f 00000000 09 0 a500001f 0
rd_s1_w0    0 2 341 0 00 00000000 0a 0 a5000010 0
rw_s0_w1    1 1 340 0 00 deadbeef 0b 0 00000000 0
rd_s0_w0_b  0 2 340 0 00 00000000 0c 0 12345670 0
rd_s0_w1    1 2 340 0 00 00000000 0d 0 deadbeef 0
rd_s1_w2    2 2 341 0 00 00000000 0e 0 00000000 0
wr_wid_w2   2 1 cc3 0 00 ffffffff 0f 0 00000002 0
rd_wid_w2   2 2 cc3 0 00 00000000 10 0 00000002 0
wtid_w0     0 2 cc0 0 00 00000000 11 0 00000000 0
wtid_w1     1 2 cc0 0 00 00000000 12 0 00000001 0
wtid_w2     2 2 cc0 0 00 00000000 13 0 00000002 0
wtid_w3     3 2 cc0 0 00 00000000 14 0 00000003 0
ltid_w0     0 2 cc1 0 00 00000000 15 0 00000000 0
ltid_w1     1 2 cc1 0 00 00000000 16 0 00000001 0
ltid_w2     2 2 cc1 0 00 00000000 17 0 00000002 0
ltid_w3     3 2 cc1 0 00 00000000 18 0 00000003 0
instret_a   1 2 c02 0 00 00000000 19 0 00000000 0
cycle_a     3 2 c00 0 00 00000000 1a 0 00000000 0
cycle_b     3 2 c00 0 00 00000000 1b 0 00000000 0
instret_b   2 2 c02 0 00 00000000 1c 0 00000000 0
stall_w1    1 2 340 0 00 00000000 1d 1 deadbeef 0
stall_rw_w3 3 1 341 0 00 00c0ffee 1e 1 00000000 0
rd_s1_w3    3 2 341 0 00 00000000 1f 0 00c0ffee 0
bp_rs1      2 2 340 0 00 00000001 01 0 00000000 1
bp_rs2      2 2 340 0 00 00000010 02 0 00000001 1
bp_rs3      2 2 340 1 04 00000000 03 0 00000011 1
bp_rs4      2 2 340 0 00 80000000 04 0 00000015 1
bp_rc5      2 3 340 0 00 00000001 05 0 80000015 1
bp_rd       2 2 340 0 00 00000000 06 0 80000014 1
bp_instret  1 2 c02 0 00 00000000 07 0 00000000 1

/* test/csr_block_tb.sv */
`timescale 1ns/1ns

module csr_block_tb;

    localparam int max_tests = 64;

    typedef struct packed {
        csr_pkg::csr_req_t req;
        logic              stall;
        logic [31:0]       expected;
        logic              bp;
    } test_vec_t;

    logic                          clk = 1'b0;
    logic                          reset;
    logic                          req_valid;
    csr_pkg::csr_req_t             req;
    logic                          req_ready;
    logic [csr_pkg::num_warps-1:0] stall;
    logic                          rsp_valid;
    logic                          rsp_ready;
    csr_pkg::csr_rsp_t             rsp;
    logic [csr_pkg::num_warps-1:0] pending;

    test_vec_t   tv [max_tests];
    string       names [max_tests];
    logic [31:0] instret_exp [max_tests];
    int          num_tests;
    bit          loaded;
    int          passed;
    int          failed;
    int          errors;
    integer      seed;
    bit          have_cycle;
    logic [31:0] last_cycle;

    csr_block u_csr_block (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .stall     (stall),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp),
        .pending   (pending)
    );

    always #4 clk = ~clk;

    task automatic load_tests();
        int          fd;
        int          n;
        string       line;
        string       name;
        logic [31:0] f_wid, f_op, f_addr, f_use, f_imm, f_rs1, f_rd, f_stall, f_exp, f_bp;
        fd = $fopen("test/csr_tests.txt", "r");
        num_tests = 0;
        if (fd == 0) begin
            $display("Error: cannot open test/csr_tests.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#" && num_tests < max_tests) begin
                    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h", name, f_wid, f_op,
                                f_addr, f_use, f_imm, f_rs1, f_rd, f_stall, f_exp, f_bp);
                    if (n == 11) begin
                        names[num_tests]            = name;
                        tv[num_tests].req.wid       = f_wid[csr_pkg::nw_bits-1:0];
                        tv[num_tests].req.tmask     = 4'(num_tests) | 4'b0001;
                        tv[num_tests].req.op        = csr_pkg::csr_op_t'(f_op[1:0]);
                        tv[num_tests].req.addr      = f_addr[csr_pkg::addr_bits-1:0];
                        tv[num_tests].req.use_imm   = f_use[0];
                        tv[num_tests].req.imm       = f_imm[4:0];
                        tv[num_tests].req.rs1_data  = f_rs1;
                        tv[num_tests].req.rd        = f_rd[csr_pkg::nr_bits-1:0];
                        tv[num_tests].stall         = f_stall[0];
                        tv[num_tests].expected      = f_exp;
                        tv[num_tests].bp            = f_bp[0];
                        num_tests++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Expected lanes come from the old value and the lane rules.
    task automatic check_response(input int idx);
        logic [31:0] base;
        logic [31:0] exp_lane;
        logic [31:0] bad_exp;
        logic [31:0] bad_act;
        bit          ok;
        ok   = 1'b1;
        base = tv[idx].expected;
        if (tv[idx].req.addr == csr_pkg::csr_instret) begin
            base = instret_exp[idx];
        end
        if (tv[idx].req.addr == csr_pkg::csr_cycle) begin
            base = rsp.data[0];
            if (have_cycle && rsp.data[0] <= last_cycle) begin
                ok      = 1'b0;
                bad_exp = last_cycle + 32'd1;
                bad_act = rsp.data[0];
            end
            have_cycle = 1'b1;
            last_cycle = rsp.data[0];
        end
        for (int i = 0; i < csr_pkg::num_threads; i++) begin
            if (tv[idx].req.addr == csr_pkg::csr_wtid) begin
                exp_lane = 32'(i);
            end else if (tv[idx].req.addr == csr_pkg::csr_ltid) begin
                exp_lane = base * 32'd4 + 32'(i);
            end else begin
                exp_lane = base;
            end
            if (ok && rsp.data[i] !== exp_lane) begin
                ok      = 1'b0;
                bad_exp = exp_lane;
                bad_act = rsp.data[i];
            end
        end
        if (ok && {rsp.wid, rsp.tmask, rsp.rd} !== {tv[idx].req.wid, tv[idx].req.tmask,
                                                    tv[idx].req.rd}) begin
            ok      = 1'b0;
            bad_exp = 32'({tv[idx].req.wid, tv[idx].req.tmask, tv[idx].req.rd});
            bad_act = 32'({rsp.wid, rsp.tmask, rsp.rd});
        end
        if (ok) begin
            $display("Pass %s", names[idx]);
            passed++;
        end else begin
            $display("Fail %s expected %h actual %h", names[idx], bad_exp, bad_act);
            failed++;
        end
    endtask

    initial begin
        wait (loaded);
        repeat (num_tests * 200) @(posedge clk);
        $display("Timeout: tests did not finish within %0d cycles", num_tests * 200);
        $display("Something failed");
        $finish;
    end

    initial begin
        int          issue;
        int          done;
        int          stall_left;
        int          clear_wid;
        bit          req_fire;
        bit          rsp_fire;
        bit          may_issue;
        logic [31:0] rnd;
        seed       = 32'hcd24b447;
        reset      = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        stall      = '0;
        rsp_ready  = 1'b1;
        passed     = 0;
        failed     = 0;
        errors     = 0;
        have_cycle = 1'b0;
        issue      = 0;
        done       = 0;
        stall_left = 0;
        clear_wid  = -1;
        load_tests();
        loaded = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        while (done < num_tests) begin
            @(negedge clk);
            req_fire = req_valid && req_ready;
            rsp_fire = rsp_valid && rsp_ready;
            if (clear_wid >= 0 && pending[clear_wid]) begin
                $display("Error: pending bit of warp %0d still set after response", clear_wid);
                errors++;
            end
            clear_wid = -1;
            if (rsp_valid && !pending[rsp.wid]) begin
                $display("Error: pending bit of warp %0d low while its response waits",
                         rsp.wid);
                errors++;
            end
            if (stall_left > 0 && (req_ready || rsp_valid)) begin
                $display("Error: stalled warp %0d was accepted or answered", req.wid);
                errors++;
            end
            if (req_fire) begin
                instret_exp[issue] = 32'(done);
                issue++;
            end
            if (rsp_fire) begin
                check_response(done);
                if (tv[done].stall) begin
                    clear_wid = tv[done].req.wid;
                end
                done++;
            end
            @(posedge clk);
            #1;
            if (stall_left > 0) begin
                stall_left--;
                if (stall_left == 0) begin
                    stall = '0;
                end
            end
            if (req_fire) begin
                req_valid = 1'b0;
            end
            // Stall tests run alone so the pending bit can be seen to clear.
            may_issue = (issue < num_tests) && (done == issue || !tv[issue].stall)
                     && (issue == 0 || done == issue || !tv[issue-1].stall);
            if (!req_valid && may_issue) begin
                req       = tv[issue].req;
                req_valid = 1'b1;
                if (tv[issue].stall) begin
                    stall[tv[issue].req.wid] = 1'b1;
                    stall_left = 10;
                end
            end
            rnd = $random(seed);
            rsp_ready = (done < num_tests && tv[done].bp) ? rnd[0] : 1'b1;
        end
        $display("Summary: %0d passed, %0d failed, %0d other errors", passed, failed, errors);
        if (num_tests > 0 && failed == 0 && errors == 0 && passed == num_tests) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* logic/csr_block.sv */
`timescale 1ns/1ns

module csr_block (
    input  logic                          clk,
    input  logic                          reset,

    input  logic                          req_valid,
    input  csr_pkg::csr_req_t             req,
    output logic                          req_ready,
    input  logic [csr_pkg::num_warps-1:0] stall,

    output logic                          rsp_valid,
    input  logic                          rsp_ready,
    output csr_pkg::csr_rsp_t             rsp,
    output logic [csr_pkg::num_warps-1:0] pending
);

    logic [csr_pkg::nw_bits-1:0]   rd_wid;
    logic [csr_pkg::addr_bits-1:0] rd_addr;
    logic [31:0]                   file_data;
    logic                          file_hit;
    logic [31:0]                   cnt_data;
    logic                          cnt_hit;
    logic                          wr_enable;
    logic [csr_pkg::nw_bits-1:0]   wr_wid;
    logic [csr_pkg::addr_bits-1:0] wr_addr;
    logic [31:0]                   wr_data;
    logic                          retire;

    csr_file u_csr_file (
        .clk          (clk),
        .reset        (reset),
        .read_wid     (rd_wid),
        .read_addr    (rd_addr),
        .read_data    (file_data),
        .read_hit     (file_hit),
        .write_enable (wr_enable),
        .write_wid    (wr_wid),
        .write_addr   (wr_addr),
        .write_data   (wr_data)
    );

    csr_counters u_csr_counters (
        .clk       (clk),
        .reset     (reset),
        .retire    (retire),
        .read_wid  (rd_wid),
        .read_addr (rd_addr),
        .read_data (cnt_data),
        .read_hit  (cnt_hit)
    );

    csr_exec u_csr_exec (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .stall     (stall),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp),
        .pending   (pending),
        .rd_wid    (rd_wid),
        .rd_addr   (rd_addr),
        .file_data (file_data),
        .file_hit  (file_hit),
        .cnt_data  (cnt_data),
        .cnt_hit   (cnt_hit),
        .wr_enable (wr_enable),
        .wr_wid    (wr_wid),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .retire    (retire)
    );

endmodule

/* logic/csr_exec.sv */
`timescale 1ns/1ns

module csr_exec (
    input  logic                              clk,
    input  logic                              reset,

    input  logic                              req_valid,
    input  csr_pkg::csr_req_t                 req,
    output logic                              req_ready,
    input  logic [csr_pkg::num_warps-1:0]     stall,

    output logic                              rsp_valid,
    input  logic                              rsp_ready,
    output csr_pkg::csr_rsp_t                 rsp,
    output logic [csr_pkg::num_warps-1:0]     pending,

    output logic [csr_pkg::nw_bits-1:0]       rd_wid,
    output logic [csr_pkg::addr_bits-1:0]     rd_addr,
    input  logic [31:0]                       file_data,
    input  logic                              file_hit,
    input  logic [31:0]                       cnt_data,
    input  logic                              cnt_hit,

    output logic                              wr_enable,
    output logic [csr_pkg::nw_bits-1:0]       wr_wid,
    output logic [csr_pkg::addr_bits-1:0]     wr_addr,
    output logic [31:0]                       wr_data,
    output logic                              retire
);

    logic [31:0] operand;
    logic [31:0] read_value;
    logic        forward;
    logic [31:0] old_value;
    logic [31:0] new_value;
    logic        writable;
    logic        write_flag;
    logic        hold;
    logic        req_fire;
    logic        rsp_fire;

    // Stage contents.
    logic                                valid_q;
    logic [csr_pkg::nw_bits-1:0]         wid_q;
    logic [csr_pkg::num_threads-1:0]     tmask_q;
    logic [csr_pkg::nr_bits-1:0]         rd_q;
    logic [csr_pkg::addr_bits-1:0]       addr_q;
    logic                                we_q;
    logic [31:0]                         old_q;
    logic [31:0]                         new_q;
    logic [csr_pkg::num_warps-1:0]       pending_q;

    // Handshakes.
    assign hold      = valid_q && !rsp_ready;
    assign req_ready = !hold && !stall[req.wid];
    assign req_fire  = req_valid && req_ready;
    assign rsp_fire  = valid_q && rsp_ready;

    assign rd_wid  = req.wid;
    assign rd_addr = req.addr;

    assign operand = req.use_imm ? 32'(req.imm) : req.rs1_data;

    // Held write not yet in the file, so take its new value.
    assign forward = valid_q && we_q && (addr_q == req.addr) && (wid_q == req.wid);

    assign read_value = file_hit ? file_data : (cnt_hit ? cnt_data : 32'd0);
    assign old_value  = forward ? new_q : read_value;

    // Only the scratch registers accept writes.
    assign writable = (req.addr == csr_pkg::csr_scratch0)
                   || (req.addr == csr_pkg::csr_scratch1);

    always_comb begin
        new_value  = old_value;
        write_flag = 1'b0;
        case (req.op)
            csr_pkg::op_rw: begin
                new_value  = operand;
                write_flag = writable;
            end
            csr_pkg::op_rs: begin
                new_value  = old_value | operand;
                write_flag = writable && (operand != 32'd0);
            end
            csr_pkg::op_rc: begin
                new_value  = old_value & ~operand;
                write_flag = writable && (operand != 32'd0);
            end
            default: begin
                write_flag = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (!hold) begin
            valid_q <= req_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            wid_q   <= req.wid;
            tmask_q <= req.tmask;
            rd_q    <= req.rd;
            addr_q  <= req.addr;
            we_q    <= write_flag;
            old_q   <= old_value;
            new_q   <= new_value;
        end
    end

    // Set wins so a warp re-entering on its leaving edge stays pending.
    always_ff @(posedge clk) begin
        if (reset) begin
            pending_q <= '0;
        end else begin
            if (rsp_fire) begin
                pending_q[wid_q] <= 1'b0;
            end
            if (req_fire) begin
                pending_q[req.wid] <= 1'b1;
            end
        end
    end

    assign pending = pending_q;

    // Write commits with the response.
    assign wr_enable = rsp_fire && we_q;
    assign wr_wid    = wid_q;
    assign wr_addr   = addr_q;
    assign wr_data   = new_q;
    assign retire    = rsp_fire;

    assign rsp_valid = valid_q;

    always_comb begin
        rsp.wid   = wid_q;
        rsp.tmask = tmask_q;
        rsp.rd    = rd_q;
        for (int i = 0; i < csr_pkg::num_threads; i++) begin
            if (addr_q == csr_pkg::csr_wtid) begin
                rsp.data[i] = 32'(i);
            end else if (addr_q == csr_pkg::csr_ltid) begin
                rsp.data[i] = old_q * 32'(csr_pkg::num_threads) + 32'(i);
            end else begin
                rsp.data[i] = old_q;
            end
        end
    end

endmodule

/* logic/csr_counters.sv */
`timescale 1ns/1ns

module csr_counters (
    input  logic                          clk,
    input  logic                          reset,

    input  logic                          retire,

    input  logic [csr_pkg::nw_bits-1:0]   read_wid,
    input  logic [csr_pkg::addr_bits-1:0] read_addr,
    output logic [31:0]                   read_data,
    output logic                          read_hit
);

    logic [31:0] cycle_count;
    logic [31:0] instret_count;
    logic [31:0] wid_value;

    always_ff @(posedge clk) begin
        if (reset) begin
            cycle_count   <= '0;
            instret_count <= '0;
        end else begin
            cycle_count <= cycle_count + 32'd1;
            if (retire) begin
                instret_count <= instret_count + 32'd1;
            end
        end
    end

    // Lane part of wtid and ltid is filled in per lane later.
    assign wid_value = 32'(read_wid);

    always_comb begin
        read_hit  = 1'b1;
        read_data = 32'd0;
        case (read_addr)
            csr_pkg::csr_cycle: begin
                read_data = cycle_count;
            end
            csr_pkg::csr_instret: begin
                read_data = instret_count;
            end
            csr_pkg::csr_wid,
            csr_pkg::csr_wtid,
            csr_pkg::csr_ltid: begin
                read_data = wid_value;
            end
            default: begin
                read_hit = 1'b0;
            end
        endcase
    end

endmodule

/* logic/csr_file.sv */
`timescale 1ns/1ns

module csr_file (
    input  logic                          clk,
    input  logic                          reset,

    input  logic [csr_pkg::nw_bits-1:0]   read_wid,
    input  logic [csr_pkg::addr_bits-1:0] read_addr,
    output logic [31:0]                   read_data,
    output logic                          read_hit,

    input  logic                          write_enable,
    input  logic [csr_pkg::nw_bits-1:0]   write_wid,
    input  logic [csr_pkg::addr_bits-1:0] write_addr,
    input  logic [31:0]                   write_data
);

    // Two words per warp, register 0 and register 1.
    logic [1:0][31:0] scratch [csr_pkg::num_warps];

    logic read_sel;
    logic write_hit;
    logic write_sel;

    // Read port.
    assign read_hit = (read_addr == csr_pkg::csr_scratch0)
                   || (read_addr == csr_pkg::csr_scratch1);
    assign read_sel = (read_addr == csr_pkg::csr_scratch1);

    always_comb begin
        if (read_hit) begin
            read_data = scratch[read_wid][read_sel];
        end else begin
            read_data = 32'd0;
        end
    end

    // Write port, other addresses fall through.
    assign write_hit = (write_addr == csr_pkg::csr_scratch0)
                    || (write_addr == csr_pkg::csr_scratch1);
    assign write_sel = (write_addr == csr_pkg::csr_scratch1);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < csr_pkg::num_warps; w++) begin
                scratch[w] <= '0;
            end
        end else if (write_enable && write_hit) begin
            scratch[write_wid][write_sel] <= write_data;
        end
    end

endmodule

/* logic/csr_pkg.sv */
package csr_pkg;

    // Core shape.
    localparam int num_warps   = 4;
    localparam int num_threads = 4;
    localparam int nw_bits     = 2;
    localparam int nr_bits     = 5;
    localparam int addr_bits   = 12;

    // Per-warp scratch registers.
    localparam logic [addr_bits-1:0] csr_scratch0 = 12'h340;
    localparam logic [addr_bits-1:0] csr_scratch1 = 12'h341;

    // Read-only counters.
    localparam logic [addr_bits-1:0] csr_cycle    = 12'hC00;
    localparam logic [addr_bits-1:0] csr_instret  = 12'hC02;

    // Read-only thread identity.
    localparam logic [addr_bits-1:0] csr_wtid     = 12'hCC0;
    localparam logic [addr_bits-1:0] csr_ltid     = 12'hCC1;
    localparam logic [addr_bits-1:0] csr_wid      = 12'hCC3;

    // Same codes as funct3 of the CSR instructions.
    typedef enum logic [1:0] {
        op_rw = 2'd1,
        op_rs = 2'd2,
        op_rc = 2'd3
    } csr_op_t;

    typedef struct packed {
        logic [nw_bits-1:0]     wid;
        logic [num_threads-1:0] tmask;
        csr_op_t                op;
        logic [addr_bits-1:0]   addr;
        logic                   use_imm;
        logic [4:0]             imm;
        logic [31:0]            rs1_data;
        logic [nr_bits-1:0]     rd;
    } csr_req_t;

    typedef struct packed {
        logic [nw_bits-1:0]           wid;
        logic [num_threads-1:0]       tmask;
        logic [nr_bits-1:0]           rd;
        logic [num_threads-1:0][31:0] data;
    } csr_rsp_t;

endpackage
